// ==== list.f ====
rtl/video_pkg.sv
rtl/display_timing.sv
rtl/framebuffer.sv
rtl/palette_lut.sv
rtl/pixel_scanout.sv
rtl/fb_display_top.sv
bench/tb_fb_display.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and search the output for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_fb_display -f list.f -o sim_tb \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx "TB PASSED" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== bench/tb_fb_display.sv ====
`timescale 1ns/1ps

module tb_fb_display;

    localparam int FRAME_CYC = video_pkg::H_TOTAL * video_pkg::V_TOTAL;
    localparam int HS_START  = video_pkg::H_ACTIVE + video_pkg::H_FRONT;  // first hsync pixel
    localparam int VS_START  = video_pkg::V_ACTIVE + video_pkg::V_FRONT;  // first vsync line

    typedef enum int {K_PAL_FILL, K_PAL, K_PIX, K_CLEAR, K_FRAME} kind_t;
    typedef struct packed {
        kind_t                       kind;
        int                          arg;   // palette index, clear value or write count
        int                          cnt;   // host writes tried in the last cycles of the sweep
        logic [video_pkg::COLRW-1:0] colr;
        int                          exp;   // expected clear_busy cycles
    } step_t;

    logic                           clk_pix;
    logic                           arst_n;
    logic                           fb_we;
    logic [video_pkg::FB_ADDRW-1:0] fb_addr;
    logic [video_pkg::FB_DATAW-1:0] fb_data;
    logic                           clear;
    logic [video_pkg::FB_DATAW-1:0] clear_value;
    logic                           pal_we;
    logic [video_pkg::FB_DATAW-1:0] pal_index;
    logic [video_pkg::COLRW-1:0]    pal_colr;
    logic                           clear_busy;
    logic                           vga_hsync;
    logic                           vga_vsync;
    logic [video_pkg::CHANW-1:0]    vga_r;
    logic [video_pkg::CHANW-1:0]    vga_g;
    logic [video_pkg::CHANW-1:0]    vga_b;

    logic [video_pkg::FB_DATAW-1:0] fb_mirror [video_pkg::FB_PIXELS];
    logic [video_pkg::COLRW-1:0]    pal_mirror [video_pkg::PAL_SIZE];
    step_t       steps[$];
    string       names[$];  // empty for set-up steps
    logic [15:0] lfsr = 16'd11;
    int unsigned edge_cnt = 0;
    int          err_cnt = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    bit          table_ready = 1'b0;

    fb_display_top u_dut (.*);

    always #4 clk_pix = ~clk_pix;

    // rising edges since reset release
    always @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            edge_cnt <= 0;
        end else begin
            edge_cnt <= edge_cnt + 1;
        end
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // linear screen position shown on the pins now
    function automatic int pin_pos();
        return int'((edge_cnt - video_pkg::SCAN_LATENCY) % FRAME_CYC);
    endfunction

    function automatic void add_step(kind_t kind, int arg, int cnt,
                                     logic [video_pkg::COLRW-1:0] colr, int exp, string name);
        steps.push_back(step_t'{kind, arg, cnt, colr, exp});
        names.push_back(name);
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_idle();
        check_value("vga_hsync", int'(vga_hsync), 1);
        check_value("vga_vsync", int'(vga_vsync), 1);
        check_value("vga_rgb", int'({vga_r, vga_g, vga_b}), 0);
        check_value("clear_busy", int'(clear_busy), 0);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic write_palette(input int idx, input logic [video_pkg::COLRW-1:0] colr);
        @(negedge clk_pix);
        pal_we    = 1'b1;
        pal_index = video_pkg::FB_DATAW'(idx);
        pal_colr  = colr;
        pal_mirror[video_pkg::FB_DATAW'(idx)] = colr;
        @(negedge clk_pix);
        pal_we = 1'b0;
    endtask

    task automatic write_pixels(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk_pix);
            fb_we   = 1'b1;
            fb_addr = video_pkg::FB_ADDRW'(take_bits(video_pkg::FB_ADDRW));
            fb_data = video_pkg::FB_DATAW'(take_bits(video_pkg::FB_DATAW));
            if (!clear_busy && int'(fb_addr) < video_pkg::FB_PIXELS) begin  // out of range dropped
                fb_mirror[fb_addr] = fb_data;
            end
        end
        @(negedge clk_pix);
        fb_we = 1'b0;
    endtask

    task automatic run_clear(input int value, input int wr_cnt, input int exp_busy);
        int busy_cyc;
        busy_cyc = 0;
        @(negedge clk_pix);
        clear       = 1'b1;
        clear_value = video_pkg::FB_DATAW'(value);
        @(negedge clk_pix);
        clear = 1'b0;
        while (clear_busy && busy_cyc <= 2 * exp_busy) begin
            busy_cyc++;
            fb_we = 1'b0;
            if (busy_cyc > exp_busy - wr_cnt) begin  // mostly hits addresses already swept
                fb_we   = 1'b1;
                fb_addr = video_pkg::FB_ADDRW'(take_bits(video_pkg::FB_ADDRW));
                fb_data = video_pkg::FB_DATAW'(take_bits(video_pkg::FB_DATAW));
            end
            @(negedge clk_pix);
        end
        fb_we = 1'b0;
        assert (!clear_busy) else begin
            $display("clear_busy still high after %0d cycles of sweep", busy_cyc);
            err_cnt++;
        end
        check_value("clear_busy cycles", busy_cyc, exp_busy);
        for (int i = 0; i < video_pkg::FB_PIXELS; i++) begin
            fb_mirror[video_pkg::FB_ADDRW'(i)] = video_pkg::FB_DATAW'(value);
        end
    endtask

    // one whole frame of pins from position 0
    task automatic check_frame();
        int pos;
        int x;
        int y;
        int addr;
        int exp_c;
        @(negedge clk_pix);
        while (pin_pos() != 0) begin
            @(negedge clk_pix);
        end
        for (int n = 0; n < FRAME_CYC; n++) begin
            pos = pin_pos();
            x   = pos % video_pkg::H_TOTAL;
            y   = pos / video_pkg::H_TOTAL;
            if (x >= video_pkg::H_ACTIVE || y >= video_pkg::V_ACTIVE) begin
                exp_c = 0;  // blanking
            end else if (x < video_pkg::FB_WIDTH && y < video_pkg::FB_HEIGHT) begin
                addr  = y * video_pkg::FB_WIDTH + x;
                exp_c = int'(pal_mirror[fb_mirror[video_pkg::FB_ADDRW'(addr)]]);
            end else begin
                exp_c = int'(video_pkg::BG_COLR);
            end
            check_value("vga_hsync", int'(vga_hsync),
                        int'(!(x >= HS_START && x < HS_START + video_pkg::H_SYNC)));
            check_value("vga_vsync", int'(vga_vsync),
                        int'(!(y >= VS_START && y < VS_START + video_pkg::V_SYNC)));
            check_value("vga_rgb", int'({vga_r, vga_g, vga_b}), exp_c);
            @(negedge clk_pix);
        end
    endtask

    initial begin
        int    errs;
        step_t s;
        clk_pix     = 1'b0;
        arst_n      = 1'b0;
        fb_we       = 1'b0;
        fb_addr     = '0;
        fb_data     = '0;
        clear       = 1'b0;
        clear_value = '0;
        pal_we      = 1'b0;
        pal_index   = '0;
        pal_colr    = '0;
        add_step(K_PAL_FILL, 0, 0, 12'h000, 0, "");
        add_step(K_CLEAR, 5, 0, 12'h000, video_pkg::FB_PIXELS, "clear busy length");
        add_step(K_FRAME, 0, 0, 12'h000, 0, "sync timing and cleared frame");
        add_step(K_PIX, 400, 0, 12'h000, 0, "");
        add_step(K_FRAME, 0, 0, 12'h000, 0, "pixel writes");
        add_step(K_CLEAR, 9, 300, 12'h000, video_pkg::FB_PIXELS, "clear with host writes");
        add_step(K_FRAME, 0, 0, 12'h000, 0, "writes during clear ignored");
        add_step(K_PIX, 200, 0, 12'h000, 0, "");
        add_step(K_PAL, 9, 0, 12'habc, 0, "");  // index 9 still fills most of the area
        add_step(K_FRAME, 0, 0, 12'h000, 0, "palette change");
        table_ready = 1'b1;
        errs = err_cnt;
        repeat (2) begin
            @(negedge clk_pix);
            check_idle();
        end
        arst_n = 1'b1;
        repeat (video_pkg::SCAN_LATENCY) begin  // pipeline still holds reset values
            check_idle();
            @(negedge clk_pix);
        end
        finish_test("reset state", errs);
        foreach (steps[i]) begin
            s    = steps[i];
            errs = err_cnt;
            case (s.kind)
                K_PAL_FILL: begin
                    for (int k = 0; k < video_pkg::PAL_SIZE; k++) begin
                        write_palette(k, video_pkg::COLRW'(take_bits(video_pkg::COLRW)));
                    end
                end
                K_PAL:   write_palette(s.arg, s.colr);
                K_PIX:   write_pixels(s.arg);
                K_CLEAR: run_clear(s.arg, s.cnt, s.exp);
                default: check_frame();
            endcase
            if (names[i] != "") begin
                finish_test(names[i], errs);
            end
        end
        $display("tests passed %0d, failed %0d, check errors %0d", n_pass, n_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // two frames per frame check plus one spare and a 20 percent margin
    initial begin
        longint budget;
        int     frames;
        frames = 1;
        wait (table_ready);
        foreach (steps[i]) begin
            if (steps[i].kind == K_FRAME) begin
                frames += 2;
            end
        end
        budget = longint'(frames) * FRAME_CYC * 8 * 12 / 10;
        #(budget);
        $display("watchdog expired after %0d ns, the run did not complete", budget);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== rtl/fb_display_top.sv ====
`timescale 1ns/1ps

module fb_display_top (
    input  wire logic                           clk_pix,
    input  wire logic                           arst_n,
    input  wire logic                           fb_we,
    input  wire logic [video_pkg::FB_ADDRW-1:0] fb_addr,
    input  wire logic [video_pkg::FB_DATAW-1:0] fb_data,
    input  wire logic                           clear,
    input  wire logic [video_pkg::FB_DATAW-1:0] clear_value,
    input  wire logic                           pal_we,
    input  wire logic [video_pkg::FB_DATAW-1:0] pal_index,
    input  wire logic [video_pkg::COLRW-1:0]    pal_colr,
    output      logic                           clear_busy,
    output      logic                           vga_hsync,
    output      logic                           vga_vsync,
    output      logic [video_pkg::CHANW-1:0]    vga_r,
    output      logic [video_pkg::CHANW-1:0]    vga_g,
    output      logic [video_pkg::CHANW-1:0]    vga_b
);

    logic [video_pkg::CORDW-1:0]   sx;
    logic [video_pkg::CORDW-1:0]   sy;
    logic                          hsync;
    logic                          vsync;
    logic                          de;
    logic [video_pkg::FB_ADDRW-1:0] rd_addr;
    logic [video_pkg::FB_DATAW-1:0] rd_data;  // palette index from memory
    logic [video_pkg::COLRW-1:0]    colr;

    display_timing u_timing (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de)
    );

    framebuffer u_fb (
        .clk_pix     (clk_pix),
        .arst_n      (arst_n),
        .fb_we       (fb_we),
        .fb_addr     (fb_addr),
        .fb_data     (fb_data),
        .clear       (clear),
        .clear_value (clear_value),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .clear_busy  (clear_busy)
    );

    palette_lut u_pal (
        .clk_pix   (clk_pix),
        .pal_we    (pal_we),
        .pal_index (pal_index),
        .pal_colr  (pal_colr),
        .index     (rd_data),
        .colr      (colr)
    );

    pixel_scanout u_scan (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .sx        (sx),
        .sy        (sy),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .colr      (colr),
        .rd_addr   (rd_addr),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

// ==== rtl/pixel_scanout.sv ====
`timescale 1ns/1ps

module pixel_scanout (
    input  wire logic                           clk_pix,
    input  wire logic                           arst_n,
    input  wire logic [video_pkg::CORDW-1:0]    sx,
    input  wire logic [video_pkg::CORDW-1:0]    sy,
    input  wire logic                           hsync,
    input  wire logic                           vsync,
    input  wire logic                           de,
    input  wire logic [video_pkg::COLRW-1:0]    colr,
    output      logic [video_pkg::FB_ADDRW-1:0] rd_addr,
    output      logic                           vga_hsync,
    output      logic                           vga_vsync,
    output      logic [video_pkg::CHANW-1:0]    vga_r,
    output      logic [video_pkg::CHANW-1:0]    vga_g,
    output      logic [video_pkg::CHANW-1:0]    vga_b
);

    logic                           in_area;   // coordinate inside framebuffer
    logic [video_pkg::FB_ADDRW-1:0] row_base;  // sy * 160
    logic [video_pkg::FB_ADDRW-1:0] lin_addr;

    // delay lines, index 2 lines up with colr
    logic [2:0] hs_dly;
    logic [2:0] vs_dly;
    logic [2:0] de_dly;
    logic [2:0] area_dly;

    logic [video_pkg::COLRW-1:0] disp_colr;

    always_comb begin
        in_area  = (sx < video_pkg::CORDW'(video_pkg::FB_WIDTH)) &&
                   (sy < video_pkg::CORDW'(video_pkg::FB_HEIGHT));
        row_base = (video_pkg::FB_ADDRW'(sy) << 7) + (video_pkg::FB_ADDRW'(sy) << 5);  // 128 + 32
        lin_addr = row_base + video_pkg::FB_ADDRW'(sx);
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            rd_addr <= '0;
        end else if (in_area) begin  // hold last address outside the area
            rd_addr <= lin_addr;
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hs_dly   <= '1;  // syncs idle high
            vs_dly   <= '1;
            de_dly   <= '0;
            area_dly <= '0;
        end else begin
            hs_dly   <= {hs_dly[1:0], hsync};
            vs_dly   <= {vs_dly[1:0], vsync};
            de_dly   <= {de_dly[1:0], de};
            area_dly <= {area_dly[1:0], in_area};
        end
    end

    // palette colour in area, background elsewhere, black in blanking
    always_comb begin
        if (!de_dly[2]) begin
            disp_colr = '0;
        end else if (area_dly[2]) begin
            disp_colr = colr;
        end else begin
            disp_colr = video_pkg::BG_COLR;
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            {vga_r, vga_g, vga_b} <= '0;
        end else begin
            vga_hsync <= hs_dly[2];
            vga_vsync <= vs_dly[2];
            {vga_r, vga_g, vga_b} <= disp_colr;
        end
    end

endmodule

// ==== rtl/palette_lut.sv ====
`timescale 1ns/1ps

module palette_lut (
    input  wire logic                           clk_pix,
    input  wire logic                           pal_we,
    input  wire logic [video_pkg::FB_DATAW-1:0] pal_index,
    input  wire logic [video_pkg::COLRW-1:0]    pal_colr,
    input  wire logic [video_pkg::FB_DATAW-1:0] index,
    output      logic [video_pkg::COLRW-1:0]    colr
);

    logic [video_pkg::COLRW-1:0] table_mem [video_pkg::PAL_SIZE];  // 12-bit rgb entries

    always_ff @(posedge clk_pix) begin
        if (pal_we) begin
            table_mem[pal_index] <= pal_colr;
        end
    end

    // registered lookup of the streamed index
    always_ff @(posedge clk_pix) begin
        colr <= table_mem[index];
    end

endmodule

// ==== rtl/framebuffer.sv ====
`timescale 1ns/1ps

module framebuffer (
    input  wire logic                             clk_pix,
    input  wire logic                             arst_n,
    input  wire logic                             fb_we,
    input  wire logic [video_pkg::FB_ADDRW-1:0]   fb_addr,
    input  wire logic [video_pkg::FB_DATAW-1:0]   fb_data,
    input  wire logic                             clear,
    input  wire logic [video_pkg::FB_DATAW-1:0]   clear_value,
    input  wire logic [video_pkg::FB_ADDRW-1:0]   rd_addr,
    output      logic [video_pkg::FB_DATAW-1:0]   rd_data,
    output      logic                             clear_busy
);

    logic [video_pkg::FB_DATAW-1:0] mem [video_pkg::FB_PIXELS];

    logic [video_pkg::FB_ADDRW-1:0] sweep_addr;   // next address to clear
    logic [video_pkg::FB_DATAW-1:0] sweep_value;  // latched on clear pulse

    logic                           wr_en;
    logic [video_pkg::FB_ADDRW-1:0] wr_addr;
    logic [video_pkg::FB_DATAW-1:0] wr_data;

    // the sweep owns the write port while busy
    always_comb begin
        if (clear_busy) begin
            wr_en   = 1'b1;
            wr_addr = sweep_addr;
            wr_data = sweep_value;
        end else begin
            wr_en   = fb_we && (fb_addr < video_pkg::FB_ADDRW'(video_pkg::FB_PIXELS));
            wr_addr = fb_addr;
            wr_data = fb_data;
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            clear_busy <= 1'b0;
            sweep_addr <= '0;
        end else if (clear) begin  // restarts a sweep in progress too
            clear_busy <= 1'b1;
            sweep_addr <= '0;
        end else if (clear_busy) begin
            if (sweep_addr == video_pkg::FB_ADDRW'(video_pkg::FB_PIXELS - 1)) begin
                clear_busy <= 1'b0;
            end
            sweep_addr <= sweep_addr + 1'b1;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (clear) begin
            sweep_value <= clear_value;
        end
    end

    // old data on a same-address collision
    always_ff @(posedge clk_pix) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== rtl/display_timing.sv ====
`timescale 1ns/1ps

module display_timing (
    input  wire logic                          clk_pix,
    input  wire logic                          arst_n,
    output      logic [video_pkg::CORDW-1:0]   sx,
    output      logic [video_pkg::CORDW-1:0]   sy,
    output      logic                          hsync,
    output      logic                          vsync,
    output      logic                          de
);

    logic line_end;   // last pixel of a line
    logic frame_end;  // last line of a frame

    assign line_end  = (sx == video_pkg::CORDW'(video_pkg::H_TOTAL - 1));
    assign frame_end = (sy == video_pkg::CORDW'(video_pkg::V_TOTAL - 1));

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else begin
            if (line_end) begin
                sx <= '0;
                if (frame_end) begin
                    sy <= '0;
                end else begin
                    sy <= sy + 1'b1;
                end
            end else begin
                sx <= sx + 1'b1;
            end
        end
    end

    // syncs are active low, decoded straight from the counts
    always_comb begin
        hsync = !(sx >= video_pkg::CORDW'(video_pkg::H_ACTIVE + video_pkg::H_FRONT) &&
                  sx <  video_pkg::CORDW'(video_pkg::H_ACTIVE + video_pkg::H_FRONT
                                          + video_pkg::H_SYNC));
        vsync = !(sy >= video_pkg::CORDW'(video_pkg::V_ACTIVE + video_pkg::V_FRONT) &&
                  sy <  video_pkg::CORDW'(video_pkg::V_ACTIVE + video_pkg::V_FRONT
                                          + video_pkg::V_SYNC));
        de    = (sx < video_pkg::CORDW'(video_pkg::H_ACTIVE)) &&
                (sy < video_pkg::CORDW'(video_pkg::V_ACTIVE));  // active picture
    end

endmodule

// ==== rtl/video_pkg.sv ====
package video_pkg;

    // 640x480 at 60 Hz, 25.2 MHz pixel clock
    localparam int H_ACTIVE = 640;  // visible pixels per line
    localparam int H_FRONT  = 16;   // front porch
    localparam int H_SYNC   = 96;   // sync pulse width
    localparam int H_BACK   = 48;   // back porch
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    localparam int V_ACTIVE = 480;  // visible lines
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam int CORDW = 10;  // unsigned screen coordinate width

    // framebuffer geometry
    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);  // 15 bits
    localparam int FB_DATAW  = 4;  // palette index bits per pixel

    // colour
    localparam int CHANW = 4;          // bits per channel
    localparam int COLRW = 3 * CHANW;  // packed r,g,b
    localparam int PAL_SIZE = 2 ** FB_DATAW;

    localparam logic [COLRW-1:0] BG_COLR = 12'h137;  // outside framebuffer

    // addr reg + fb read + palette read + output reg
    localparam int SCAN_LATENCY = 4;

endpackage
